// ==== core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// datapath widths
`define DATA_WIDTH 32
`define INSTR_WIDTH 32

// register file geometry
`define REG_ADDR_WIDTH 5
`define NUM_REGS 32

// fields from the msb down are opcode, rs and rt, then rd, shamt and funct or the imm
`define OPCODE_WIDTH 6
`define SHAMT_WIDTH 5
`define FUNCT_WIDTH 6
`define IMM_WIDTH 16

`endif

// ==== isaPkg.sv ====
`include "core_cfg.svh"

package isaPkg;

    // any opcode missing here decodes as a no-op
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        rType = 6'h00,
        addi  = 6'h08,
        slti  = 6'h0a,
        andi  = 6'h0c,
        ori   = 6'h0d
    } opcodeT;

    typedef enum logic [`FUNCT_WIDTH-1:0] {
        functSll = 6'h00,
        functSrl = 6'h02,
        functAdd = 6'h20,
        functSub = 6'h22,
        functAnd = 6'h24,
        functOr  = 6'h25,
        functXor = 6'h26,
        functSlt = 6'h2a
    } functT;

    // aluNop produces zero
    typedef enum logic [3:0] {
        aluNop = 4'd0,
        aluAdd = 4'd1,
        aluSub = 4'd2,
        aluAnd = 4'd3,
        aluOr  = 4'd4,
        aluXor = 4'd5,
        aluSlt = 4'd6,
        aluSll = 4'd7,
        aluSrl = 4'd8
    } aluOpT;

    typedef struct packed {
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`SHAMT_WIDTH-1:0] shamt;
        functT funct;
    } rFieldsT;

    // low half is either the r-type fields or the immediate
    typedef union packed {
        rFieldsT r;
        logic [`IMM_WIDTH-1:0] imm;
    } lowFieldsT;

    typedef struct packed {
        opcodeT opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        lowFieldsT low;
    } instrT;

endpackage

// ==== pipePkg.sv ====
`include "core_cfg.svh"

package pipePkg;

    typedef struct packed {
        logic regWrite;
        logic aluSrc;
        logic regDst;
        logic immSigned;
        isaPkg::aluOpT aluOp;
    } laneCtrlT;

    // decode register contents
    typedef struct packed {
        isaPkg::instrT instr1;
        isaPkg::instrT instr2;
        logic pairValid;
    } issuePairT;

    typedef struct packed {
        laneCtrlT ctrl;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] dstReg;
        logic [`SHAMT_WIDTH-1:0] shamt;
        logic [`DATA_WIDTH-1:0] rsVal;
        logic [`DATA_WIDTH-1:0] rtVal;
        logic [`DATA_WIDTH-1:0] imm;
    } laneExT;

    typedef struct packed {
        laneExT lane1;
        laneExT lane2;
    } execPairT;

    // wbValid already excludes register 0
    typedef struct packed {
        logic wbValid;
        logic [`REG_ADDR_WIDTH-1:0] dstReg;
        logic [`DATA_WIDTH-1:0] result;
    } laneWbT;

    typedef struct packed {
        laneWbT lane1;
        laneWbT lane2;
    } wbPairT;

endpackage

// ==== wbBus.sv ====
`include "core_cfg.svh"

interface wbBus;
    logic we1;
    logic [`REG_ADDR_WIDTH-1:0] wa1;
    logic [`DATA_WIDTH-1:0] wd1;
    logic we2;
    logic [`REG_ADDR_WIDTH-1:0] wa2;
    logic [`DATA_WIDTH-1:0] wd2;

    // driven from the writeback register
    modport source (output we1, wa1, wd1, we2, wa2, wd2);
    // register file write ports and write-through
    modport regSink (input we1, wa1, wd1, we2, wa2, wd2);
    // operand forwarding in execute
    modport fwdSink (input we1, wa1, wd1, we2, wa2, wd2);
endinterface

// ==== pipeStage.sv ====
module pipeStage #(
    parameter type payloadT = logic
) (
    input logic clk,
    input logic rst,
    input logic enable,
    input payloadT d,
    output payloadT q
);

    // zero payload means no valid work in this stage
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else if (enable) begin
            q <= d;
        end
    end

endmodule

// ==== controlUnit.sv ====
module controlUnit (
    input isaPkg::instrT instr,
    output pipePkg::laneCtrlT ctrl
);

    always_comb begin
        // default is a no-op that writes nothing
        ctrl = '0;
        case (instr.opcode)
            isaPkg::rType: begin
                ctrl.regDst = 1'b1;
                ctrl.regWrite = 1'b1;
                case (instr.low.r.funct)
                    isaPkg::functAdd: ctrl.aluOp = isaPkg::aluAdd;
                    isaPkg::functSub: ctrl.aluOp = isaPkg::aluSub;
                    isaPkg::functAnd: ctrl.aluOp = isaPkg::aluAnd;
                    isaPkg::functOr: ctrl.aluOp = isaPkg::aluOr;
                    isaPkg::functXor: ctrl.aluOp = isaPkg::aluXor;
                    isaPkg::functSlt: ctrl.aluOp = isaPkg::aluSlt;
                    isaPkg::functSll: ctrl.aluOp = isaPkg::aluSll;
                    isaPkg::functSrl: ctrl.aluOp = isaPkg::aluSrl;
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            isaPkg::addi, isaPkg::slti: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.immSigned = 1'b1;
                ctrl.aluOp = (instr.opcode == isaPkg::addi) ? isaPkg::aluAdd
                                                            : isaPkg::aluSlt;
            end
            // logical immediates are zero-extended
            isaPkg::andi, isaPkg::ori: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.aluOp = (instr.opcode == isaPkg::andi) ? isaPkg::aluAnd
                                                            : isaPkg::aluOr;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== registerFile.sv ====
`include "core_cfg.svh"

module registerFile (
    input logic clk,
    input logic rst,
    input logic enable,
    wbBus.regSink wb,
    input logic [`REG_ADDR_WIDTH-1:0] rsAddr1,
    input logic [`REG_ADDR_WIDTH-1:0] rtAddr1,
    input logic [`REG_ADDR_WIDTH-1:0] rsAddr2,
    input logic [`REG_ADDR_WIDTH-1:0] rtAddr2,
    output logic [`DATA_WIDTH-1:0] rsData1,
    output logic [`DATA_WIDTH-1:0] rtData1,
    output logic [`DATA_WIDTH-1:0] rsData2,
    output logic [`DATA_WIDTH-1:0] rtData2
);

    logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];
    logic [`REG_ADDR_WIDTH-1:0] rdAddr [4];
    logic [`DATA_WIDTH-1:0] rdData [4];

    // lane 2 written last so it wins on the same address
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (enable) begin
            if (wb.we1) begin
                regs[wb.wa1] <= wb.wd1;
            end
            if (wb.we2) begin
                regs[wb.wa2] <= wb.wd2;
            end
        end
    end

    assign rdAddr[0] = rsAddr1;
    assign rdAddr[1] = rtAddr1;
    assign rdAddr[2] = rsAddr2;
    assign rdAddr[3] = rtAddr2;

    // write-through covers the pair two positions older
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (rdAddr[p] == '0) begin
                rdData[p] = '0;
            end else if (wb.we2 && wb.wa2 == rdAddr[p]) begin
                rdData[p] = wb.wd2;
            end else if (wb.we1 && wb.wa1 == rdAddr[p]) begin
                rdData[p] = wb.wd1;
            end else begin
                rdData[p] = regs[rdAddr[p]];
            end
        end
    end

    assign rsData1 = rdData[0];
    assign rtData1 = rdData[1];
    assign rsData2 = rdData[2];
    assign rtData2 = rdData[3];

endmodule

// ==== aluUnit.sv ====
`include "core_cfg.svh"

module aluUnit (
    input isaPkg::aluOpT aluOp,
    input logic [`DATA_WIDTH-1:0] operandA,
    input logic [`DATA_WIDTH-1:0] operandB,
    input logic [`SHAMT_WIDTH-1:0] shamt,
    output logic [`DATA_WIDTH-1:0] result
);

    logic lessThan;

    assign lessThan = $signed(operandA) < $signed(operandB);

    always_comb begin
        case (aluOp)
            isaPkg::aluAdd: result = operandA + operandB;
            isaPkg::aluSub: result = operandA - operandB;
            isaPkg::aluAnd: result = operandA & operandB;
            isaPkg::aluOr: result = operandA | operandB;
            isaPkg::aluXor: result = operandA ^ operandB;
            isaPkg::aluSlt: result = {{(`DATA_WIDTH-1){1'b0}}, lessThan};
            // shifts act on rt, as in the r-type encoding
            isaPkg::aluSll: result = operandB << shamt;
            isaPkg::aluSrl: result = operandB >> shamt;
            default: result = '0;
        endcase
    end

endmodule

// ==== decodeStage.sv ====
`include "core_cfg.svh"

module decodeStage (
    input logic clk,
    input logic rst,
    input logic enable,
    input logic instrValid,
    input logic [`INSTR_WIDTH-1:0] instr1,
    input logic [`INSTR_WIDTH-1:0] instr2,
    wbBus.regSink wb,
    output pipePkg::execPairT execPair
);

    pipePkg::issuePairT issueIn;
    pipePkg::issuePairT issueQ;
    pipePkg::laneCtrlT ctrl1;
    pipePkg::laneCtrlT ctrl2;
    pipePkg::execPairT execNext;
    logic [`DATA_WIDTH-1:0] rsData1;
    logic [`DATA_WIDTH-1:0] rtData1;
    logic [`DATA_WIDTH-1:0] rsData2;
    logic [`DATA_WIDTH-1:0] rtData2;

    // builds one lane's execute payload and clears the control of an invalid pair
    function automatic pipePkg::laneExT buildLane(
        input isaPkg::instrT ins,
        input pipePkg::laneCtrlT ctrl,
        input logic valid,
        input logic [`DATA_WIDTH-1:0] rsVal,
        input logic [`DATA_WIDTH-1:0] rtVal
    );
        pipePkg::laneExT lane;
        logic fill;
        fill = ctrl.immSigned & ins.low.imm[`IMM_WIDTH-1];
        lane.ctrl = ctrl;
        if (!valid) begin
            lane.ctrl = '0;
        end
        lane.rs = ins.rs;
        lane.rt = ins.rt;
        lane.dstReg = ctrl.regDst ? ins.low.r.rd : ins.rt;
        lane.shamt = ins.low.r.shamt;
        lane.rsVal = rsVal;
        lane.rtVal = rtVal;
        lane.imm = {{(`DATA_WIDTH-`IMM_WIDTH){fill}}, ins.low.imm};
        return lane;
    endfunction

    assign issueIn.instr1 = instr1;
    assign issueIn.instr2 = instr2;
    assign issueIn.pairValid = instrValid;

    pipeStage #(.payloadT(pipePkg::issuePairT)) issueReg (
        .clk(clk), .rst(rst), .enable(enable), .d(issueIn), .q(issueQ)
    );

    controlUnit cu1 (.instr(issueQ.instr1), .ctrl(ctrl1));
    controlUnit cu2 (.instr(issueQ.instr2), .ctrl(ctrl2));

    registerFile regFile (
        .clk(clk), .rst(rst), .enable(enable), .wb(wb),
        .rsAddr1(issueQ.instr1.rs), .rtAddr1(issueQ.instr1.rt),
        .rsAddr2(issueQ.instr2.rs), .rtAddr2(issueQ.instr2.rt),
        .rsData1(rsData1), .rtData1(rtData1), .rsData2(rsData2), .rtData2(rtData2)
    );

    assign execNext.lane1 = buildLane(issueQ.instr1, ctrl1, issueQ.pairValid, rsData1, rtData1);
    assign execNext.lane2 = buildLane(issueQ.instr2, ctrl2, issueQ.pairValid, rsData2, rtData2);

    pipeStage #(.payloadT(pipePkg::execPairT)) execReg (
        .clk(clk), .rst(rst), .enable(enable), .d(execNext), .q(execPair)
    );

endmodule

// ==== executeStage.sv ====
`include "core_cfg.svh"

module executeStage (
    input logic clk,
    input logic rst,
    input logic enable,
    input pipePkg::execPairT execPair,
    wbBus.source wb,
    wbBus.fwdSink fwd
);

    pipePkg::laneExT exLane [2];
    pipePkg::laneWbT fwdLane [2];
    pipePkg::laneWbT wbLane [2];
    pipePkg::wbPairT wbNext;
    pipePkg::wbPairT wbQ;

    // writeback lane 2 first, then lane 1, else the decode-time value
    function automatic logic [`DATA_WIDTH-1:0] pickOperand(
        input logic [`REG_ADDR_WIDTH-1:0] addr,
        input logic [`DATA_WIDTH-1:0] decoded,
        input pipePkg::laneWbT older1,
        input pipePkg::laneWbT older2
    );
        if (older2.wbValid && older2.dstReg == addr) begin
            return older2.result;
        end
        if (older1.wbValid && older1.dstReg == addr) begin
            return older1.result;
        end
        return decoded;
    endfunction

    assign exLane[0] = execPair.lane1;
    assign exLane[1] = execPair.lane2;
    assign fwdLane[0] = '{wbValid: fwd.we1, dstReg: fwd.wa1, result: fwd.wd1};
    assign fwdLane[1] = '{wbValid: fwd.we2, dstReg: fwd.wa2, result: fwd.wd2};

    for (genvar i = 0; i < 2; i++) begin : gLane
        logic [`DATA_WIDTH-1:0] opA;
        logic [`DATA_WIDTH-1:0] rtFwd;
        logic [`DATA_WIDTH-1:0] opB;
        logic [`DATA_WIDTH-1:0] aluOut;

        assign opA = pickOperand(exLane[i].rs, exLane[i].rsVal, fwdLane[0], fwdLane[1]);
        assign rtFwd = pickOperand(exLane[i].rt, exLane[i].rtVal, fwdLane[0], fwdLane[1]);
        assign opB = exLane[i].ctrl.aluSrc ? exLane[i].imm : rtFwd;

        aluUnit alu (
            .aluOp(exLane[i].ctrl.aluOp), .operandA(opA), .operandB(opB),
            .shamt(exLane[i].shamt), .result(aluOut)
        );

        // writes to register 0 never leave this stage
        assign wbLane[i].wbValid = exLane[i].ctrl.regWrite && (exLane[i].dstReg != '0);
        assign wbLane[i].dstReg = exLane[i].dstReg;
        assign wbLane[i].result = aluOut;
    end

    assign wbNext.lane1 = wbLane[0];
    assign wbNext.lane2 = wbLane[1];

    pipeStage #(.payloadT(pipePkg::wbPairT)) wbReg (
        .clk(clk), .rst(rst), .enable(enable), .d(wbNext), .q(wbQ)
    );

    assign wb.we1 = wbQ.lane1.wbValid;
    assign wb.wa1 = wbQ.lane1.dstReg;
    assign wb.wd1 = wbQ.lane1.result;
    assign wb.we2 = wbQ.lane2.wbValid;
    assign wb.wa2 = wbQ.lane2.dstReg;
    assign wb.wd2 = wbQ.lane2.result;

endmodule

// ==== dualIssueCore.sv ====
`include "core_cfg.svh"

module dualIssueCore (
    input logic clk,
    input logic rst,
    input logic enable,
    input logic instrValid,
    input logic [`INSTR_WIDTH-1:0] instr1,
    input logic [`INSTR_WIDTH-1:0] instr2,
    output logic wbValid1,
    output logic [`REG_ADDR_WIDTH-1:0] wbReg1,
    output logic [`DATA_WIDTH-1:0] wbData1,
    output logic wbValid2,
    output logic [`REG_ADDR_WIDTH-1:0] wbReg2,
    output logic [`DATA_WIDTH-1:0] wbData2
);

    wbBus wbIf ();
    pipePkg::execPairT execPair;

    decodeStage decode (
        .clk(clk), .rst(rst), .enable(enable), .instrValid(instrValid),
        .instr1(instr1), .instr2(instr2), .wb(wbIf), .execPair(execPair)
    );

    // same bus feeds the register file and forwarding
    executeStage execute (
        .clk(clk), .rst(rst), .enable(enable), .execPair(execPair),
        .wb(wbIf), .fwd(wbIf)
    );

    assign wbValid1 = wbIf.we1;
    assign wbReg1 = wbIf.wa1;
    assign wbData1 = wbIf.wd1;
    assign wbValid2 = wbIf.we2;
    assign wbReg2 = wbIf.wa2;
    assign wbData2 = wbIf.wd2;

endmodule

// ==== tbDualIssueCore.sv ====
`include "core_cfg.svh"

module tbDualIssueCore;

    localparam int clkPeriod = 4;
    localparam int resetCycles = 8;
    localparam int numRandom = 200;
    localparam int numFwd = 120;
    localparam int numStall = 100;
    localparam int maxStall = 8;
    localparam int numEdge = 8;
    // 16 pairs in the register sweep, 6 pairs per no-write round, up to 4 drain slots per test
    localparam int totalPairs = 16 + numRandom + numFwd + numStall + 6 * numEdge + 5 * 4;
    localparam int watchdogCycles = totalPairs + numStall * maxStall + resetCycles + 20;

    // expected or observed writeback of one pair
    typedef struct packed {
        logic v1;
        logic [`REG_ADDR_WIDTH-1:0] r1;
        logic [`DATA_WIDTH-1:0] d1;
        logic v2;
        logic [`REG_ADDR_WIDTH-1:0] r2;
        logic [`DATA_WIDTH-1:0] d2;
    } slotT;

    logic clk;
    logic rst;
    logic enable;
    logic instrValid;
    logic [`INSTR_WIDTH-1:0] instr1;
    logic [`INSTR_WIDTH-1:0] instr2;
    logic wbValid1;
    logic [`REG_ADDR_WIDTH-1:0] wbReg1;
    logic [`DATA_WIDTH-1:0] wbData1;
    logic wbValid2;
    logic [`REG_ADDR_WIDTH-1:0] wbReg2;
    logic [`DATA_WIDTH-1:0] wbData2;

    integer seed = 1428;
    logic [`DATA_WIDTH-1:0] modelRegs [`NUM_REGS];
    slotT expQ [$];
    int slotsIssued = 0;
    int slotsChecked = 0;
    int checkCount = 0;
    int errorCount = 0;
    int testChecks;
    int testErrors;

    dualIssueCore dut (
        .clk(clk), .rst(rst), .enable(enable), .instrValid(instrValid),
        .instr1(instr1), .instr2(instr2),
        .wbValid1(wbValid1), .wbReg1(wbReg1), .wbData1(wbData1),
        .wbValid2(wbValid2), .wbReg2(wbReg2), .wbData2(wbData2)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("watchdog expired before all tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    // moves a source off the register it must not read
    function automatic logic [4:0] avoidReg(input logic [4:0] r, input logic [4:0] avoid);
        return (r == avoid) ? avoid + 5'd1 : r;
    endfunction

    function automatic logic [31:0] encR(
        input logic [5:0] fn,
        input logic [4:0] rs,
        input logic [4:0] rt,
        input logic [4:0] rd,
        input logic [4:0] sh
    );
        return {isaPkg::rType, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encI(
        input logic [5:0] op,
        input logic [4:0] rs,
        input logic [4:0] rt,
        input logic [15:0] imm
    );
        return {op, rs, rt, imm};
    endfunction

    // dst lands in rd for r-type and in rt for i-type
    function automatic logic [31:0] randomInstr(
        input logic [4:0] rs,
        input logic [4:0] rt,
        input logic [4:0] dst
    );
        logic [31:0] w;
        w = randWord();
        case (w[31:28] % 4'd12)
            4'd0: return encR(isaPkg::functAdd, rs, rt, dst, w[10:6]);
            4'd1: return encR(isaPkg::functSub, rs, rt, dst, w[10:6]);
            4'd2: return encR(isaPkg::functAnd, rs, rt, dst, w[10:6]);
            4'd3: return encR(isaPkg::functOr, rs, rt, dst, w[10:6]);
            4'd4: return encR(isaPkg::functXor, rs, rt, dst, w[10:6]);
            4'd5: return encR(isaPkg::functSlt, rs, rt, dst, w[10:6]);
            4'd6: return encR(isaPkg::functSll, rs, rt, dst, w[10:6]);
            4'd7: return encR(isaPkg::functSrl, rs, rt, dst, w[10:6]);
            4'd8: return encI(isaPkg::addi, rs, dst, w[15:0]);
            4'd9: return encI(isaPkg::slti, rs, dst, w[15:0]);
            4'd10: return encI(isaPkg::andi, rs, dst, w[15:0]);
            default: return encI(isaPkg::ori, rs, dst, w[15:0]);
        endcase
    endfunction

    // one instruction against the model registers
    function automatic void laneResult(
        input logic [31:0] ins,
        output logic wr,
        output logic [4:0] dst,
        output logic [31:0] val
    );
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        a = modelRegs[ins[25:21]];
        b = modelRegs[ins[20:16]];
        simm = {{16{ins[15]}}, ins[15:0]};
        zimm = {16'h0000, ins[15:0]};
        wr = 1'b1;
        dst = ins[20:16];
        val = '0;
        case (ins[31:26])
            isaPkg::rType: begin
                dst = ins[15:11];
                case (ins[5:0])
                    isaPkg::functAdd: val = a + b;
                    isaPkg::functSub: val = a - b;
                    isaPkg::functAnd: val = a & b;
                    isaPkg::functOr: val = a | b;
                    isaPkg::functXor: val = a ^ b;
                    isaPkg::functSlt: val = {31'b0, $signed(a) < $signed(b)};
                    isaPkg::functSll: val = b << ins[10:6];
                    isaPkg::functSrl: val = b >> ins[10:6];
                    default: wr = 1'b0;
                endcase
            end
            isaPkg::addi: val = a + simm;
            isaPkg::slti: val = {31'b0, $signed(a) < $signed(simm)};
            isaPkg::andi: val = a & zimm;
            isaPkg::ori: val = a | zimm;
            default: wr = 1'b0;
        endcase
        if (dst == 5'd0) begin
            wr = 1'b0;
        end
    endfunction

    // lane 1 retires before lane 2, so lane 2 wins on a shared destination
    function automatic slotT refExecute(
        input logic valid,
        input logic [31:0] i1,
        input logic [31:0] i2
    );
        slotT s;
        logic wr;
        logic [4:0] dst;
        logic [31:0] val;
        s = '0;
        if (valid) begin
            laneResult(i1, wr, dst, val);
            if (wr) begin
                s.v1 = 1'b1;
                s.r1 = dst;
                s.d1 = val;
                modelRegs[dst] = val;
            end
            laneResult(i2, wr, dst, val);
            if (wr) begin
                s.v2 = 1'b1;
                s.r2 = dst;
                s.d2 = val;
                modelRegs[dst] = val;
            end
        end
        return s;
    endfunction

    task automatic compareLane(
        input int lane,
        input logic expV,
        input logic [4:0] expR,
        input logic [31:0] expD,
        input logic gotV,
        input logic [4:0] gotR,
        input logic [31:0] gotD
    );
        checkCount++;
        if (expV && gotV !== 1'b1) begin
            errorCount++;
            $display("missing writeback on lane %0d for register %0d", lane, expR);
        end else if (!expV && gotV !== 1'b0) begin
            errorCount++;
            $display("unexpected writeback on lane %0d to register %0d", lane, gotR);
        end else if (expV) begin
            if (gotR !== expR) begin
                errorCount++;
                $display("Error: wbReg%0d is %h, expected %h", lane, gotR, expR);
            end
            if (gotD !== expD) begin
                errorCount++;
                $display("Error: wbData%0d is %h, expected %h", lane, gotD, expD);
            end
        end
    endtask

    // control is sampled at the edge and the outputs half a cycle later
    initial begin : compareOutputs
        logic sRst;
        logic sEn;
        slotT got;
        slotT exp;
        slotT lastOut;
        lastOut = '0;
        forever begin
            @(posedge clk);
            sRst = rst;
            sEn = enable;
            @(negedge clk);
            got = {wbValid1, wbReg1, wbData1, wbValid2, wbReg2, wbData2};
            if (sRst) begin
                checkCount++;
                if (got.v1 !== 1'b0 || got.v2 !== 1'b0) begin
                    errorCount++;
                    $display("writeback valid is set during reset");
                end
            end else if (sEn) begin
                if (expQ.size() == 0) begin
                    errorCount++;
                    $display("writeback slot arrived with no expected pair");
                end else begin
                    exp = expQ.pop_front();
                    slotsChecked++;
                    compareLane(1, exp.v1, exp.r1, exp.d1, got.v1, got.r1, got.d1);
                    compareLane(2, exp.v2, exp.r2, exp.d2, got.v2, got.r2, got.d2);
                end
            end else begin
                checkCount++;
                if (got !== lastOut) begin
                    errorCount++;
                    $display("writeback outputs changed while enable was low");
                end
            end
            lastOut = got;
        end
    end

    task automatic issuePair(input logic valid, input logic [31:0] i1, input logic [31:0] i2);
        @(posedge clk);
        enable <= 1'b1;
        instrValid <= valid;
        instr1 <= i1;
        instr2 <= i2;
        expQ.push_back(refExecute(valid, i1, i2));
        slotsIssued++;
    endtask

    // garbage on the inputs must not be taken
    task automatic holdEnableLow(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            enable <= 1'b0;
            instrValid <= 1'b1;
            instr1 <= randWord();
            instr2 <= randWord();
        end
    endtask

    // lane 2 never reads lane 1's destination
    task automatic issueRandomPair();
        logic [31:0] w;
        logic [31:0] i1;
        logic [31:0] i2;
        w = randWord();
        i1 = randomInstr(w[9:5], w[14:10], w[4:0]);
        i2 = randomInstr(avoidReg(w[19:15], w[4:0]), avoidReg(w[24:20], w[4:0]), w[29:25]);
        issuePair(1'b1, i1, i2);
    endtask

    task automatic startTest();
        testChecks = checkCount;
        testErrors = errorCount;
    endtask

    // two reset slots sit ahead of the first issued pair
    task automatic endTest(input string name, input int pairs);
        int mark;
        mark = slotsIssued;
        while (slotsChecked < mark + 2) begin
            issuePair(1'b0, randWord(), randWord());
        end
        $display("%s: %0d pairs, %0d checks, %0d errors", name, pairs,
                 checkCount - testChecks, errorCount - testErrors);
    endtask

    task automatic afterResetTest();
        logic [4:0] r2;
        startTest();
        @(negedge clk);
        checkCount++;
        if (wbValid1 !== 1'b0 || wbValid2 !== 1'b0) begin
            errorCount++;
            $display("writeback valid is set after reset");
        end
        // each register adds to itself, so a nonzero start shows up
        for (int r = 1; r < 32; r += 2) begin
            r2 = 5'(r + 1);
            issuePair(1'b1, encI(isaPkg::addi, 5'(r), 5'(r), 16'(r * 91)),
                      encI(isaPkg::addi, r2, r2, 16'hff00 + 16'(r)));
        end
        endTest("afterReset", 16);
    endtask

    task automatic forwardingTest();
        logic [4:0] recent [4];
        logic [4:0] d1;
        logic [4:0] d2;
        logic [31:0] w;
        logic [31:0] i1;
        logic [31:0] i2;
        startTest();
        recent = '{5'd1, 5'd2, 5'd3, 5'd4};
        for (int i = 0; i < numFwd; i++) begin
            w = randWord();
            d1 = avoidReg(w[24:20], 5'd0);
            d2 = avoidReg(w[29:25], 5'd0);
            // sources from the last two pairs' destinations
            i1 = randomInstr(recent[w[1:0]], recent[w[3:2]], d1);
            i2 = randomInstr(avoidReg(recent[w[5:4]], d1), avoidReg(recent[w[7:6]], d1), d2);
            issuePair(1'b1, i1, i2);
            recent[2] = recent[0];
            recent[3] = recent[1];
            recent[0] = d1;
            recent[1] = d2;
        end
        endTest("forwarding", numFwd);
    endtask

    task automatic noWriteTest();
        logic [31:0] w;
        logic [4:0] d;
        startTest();
        for (int i = 0; i < numEdge; i++) begin
            w = randWord();
            d = (w[4:0] % 5'd30) + 5'd1;
            issuePair(1'b1, {6'h23, w[25:0]}, {6'h3f, w[31:6]});
            issuePair(1'b1, encR(6'h21, w[4:0], w[9:5], w[14:10], 5'd0),
                      encR(6'h3f, w[9:5], w[14:10], w[19:15], 5'd0));
            issuePair(1'b0, encI(isaPkg::addi, 5'd0, w[4:0], w[15:0]),
                      encI(isaPkg::ori, 5'd0, w[9:5], w[31:16]));
            issuePair(1'b1, encI(isaPkg::addi, w[4:0], 5'd0, w[15:0]),
                      encR(isaPkg::functAdd, w[9:5], w[14:10], 5'd0, 5'd0));
            // both lanes write d and the next pair reads it back
            issuePair(1'b1, encI(isaPkg::addi, 5'd0, d, w[15:0]),
                      encI(isaPkg::addi, 5'd0, d, w[31:16]));
            issuePair(1'b1, encR(isaPkg::functOr, d, 5'd0, d + 5'd1, 5'd0),
                      encI(isaPkg::ori, d, d, 16'h0000));
        end
        endTest("noWrites", 6 * numEdge);
    endtask

    initial begin
        logic [31:0] w;
        rst = 1'b1;
        enable = 1'b0;
        instrValid = 1'b0;
        instr1 = '0;
        instr2 = '0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            modelRegs[i] = '0;
        end
        // decode and execute registers come out of reset empty
        expQ.push_back('0);
        expQ.push_back('0);
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;

        afterResetTest();

        startTest();
        repeat (numRandom) issueRandomPair();
        endTest("randomPairs", numRandom);

        forwardingTest();

        startTest();
        for (int i = 0; i < numStall; i++) begin
            w = randWord();
            if (w[0]) begin
                holdEnableLow(int'(w[3:1]) + 1);
            end
            issueRandomPair();
        end
        endTest("enableLow", numStall);

        noWriteTest();

        $display("totals: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+.
isaPkg.sv
pipePkg.sv
wbBus.sv
pipeStage.sv
controlUnit.sv
registerFile.sv
aluUnit.sv
decodeStage.sv
executeStage.sv
dualIssueCore.sv
tbDualIssueCore.sv

// ==== run.sh ====
#!/bin/sh
# compile and run tbDualIssueCore with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tbDualIssueCore -f project.f -o simDualIssueCore
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/simDualIssueCore > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
exit 0
